/* Makefile */
# Verilator build and run of the remote TDR testbench

SRCS := $(wildcard common/*.sv common/*.svh rtdr/*.sv hw/*.sv tb/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_rtdr_top
	./obj_dir/Vtb_rtdr_top | tee /dev/stderr | grep -x "TEST PASS" > /dev/null

obj_dir/Vtb_rtdr_top: list.f $(SRCS)
	verilator --binary --timing --top-module tb_rtdr_top -f list.f -o Vtb_rtdr_top

clean:
	rm -rf obj_dir

/* common/rtdr_cfg.svh */
// Size macros for the remote TDR bank and the boundary-scan chain model
`ifndef RTDR_CFG_SVH
`define RTDR_CFG_SVH

// ---------------------------------------------------------------------------
// Remote register bank
// ---------------------------------------------------------------------------
// Number of remote data registers behind the TAP
`define RTDR_NUM 3
// Bits per remote register
`define RTDR_WIDTH 8
// Value of shift and shadow stages out of reset
`define RTDR_RST_VAL {(`RTDR_WIDTH){1'b0}}

// ---------------------------------------------------------------------------
// Boundary-scan chain model
// ---------------------------------------------------------------------------
// Chain length, TDI enters at the top bit
`define BSCAN_LEN 3

`endif

/* common/rtdr_pkg.sv */
// Package with the per-cell strobe struct, register word and decode types
`include "rtdr_cfg.svh"

package rtdr_pkg;

   // ------------------------------------------------------------------------
   // Strobes as seen by one remote register
   // ------------------------------------------------------------------------
   // At most one field is high in any cycle
   typedef struct packed
   {
      // Load shift stage from shadow stage
      logic capture;
      // Shift right, TDI into MSB
      logic shift;
      // Load shadow stage from shift stage
      logic update;
   } rtdr_ctrl_t;

   // ------------------------------------------------------------------------
   // Data and decode
   // ------------------------------------------------------------------------
   // One remote register word
   typedef logic [`RTDR_WIDTH-1:0] rtdr_word_t;

   // One-hot register select from the instruction decode
   typedef logic [`RTDR_NUM-1:0] rtdr_sel_t;

endpackage

/* hw/bscan_emul.sv */
// Boundary-scan chain model with run-BIST bit and its own serial output
`timescale 1ns/10ps
`include "rtdr_cfg.svh"

module bscan_emul
(
   input  logic ftap_tck,
   input  logic tap_rtdr_prog_rst_b,
   input  logic ftap_tdi,
   input  logic stap_fbscan_shiftdr,
   input  logic stap_fbscan_runbist_en,
   output logic stap_abscan_tdo
);

   // Chain, bit 0 is the serial output end
   logic [`BSCAN_LEN-1:0] scan_q;
   // Run-BIST capture bit
   logic                  runbist_q;

   // ------------------------------------------------------------------------
   // Boundary chain
   // ------------------------------------------------------------------------
   // Shifts toward bit 0, TDI in at the top
   always_ff @(posedge ftap_tck or negedge tap_rtdr_prog_rst_b)
   begin
      if (!tap_rtdr_prog_rst_b)
      begin
         scan_q <= '0;
      end
      else if (stap_fbscan_shiftdr)
      begin
         scan_q <= {ftap_tdi, scan_q[`BSCAN_LEN-1:1]};
      end
   end

   // ------------------------------------------------------------------------
   // Run-BIST bit
   // ------------------------------------------------------------------------
   // Samples TDI on every edge while enabled
   always_ff @(posedge ftap_tck or negedge tap_rtdr_prog_rst_b)
   begin
      if (!tap_rtdr_prog_rst_b)
      begin
         runbist_q <= 1'b0;
      end
      else if (stap_fbscan_runbist_en)
      begin
         runbist_q <= ftap_tdi;
      end
   end

   // ------------------------------------------------------------------------
   // Serial output
   // ------------------------------------------------------------------------
   // Run-BIST takes over the output while enabled
   assign stap_abscan_tdo = stap_fbscan_runbist_en ? runbist_q : scan_q[0];

endmodule

/* hw/rtdr_top.sv */
// Top level joining strobe control, remote register bank and scan chain model
`timescale 1ns/10ps
`include "rtdr_cfg.svh"

module rtdr_top
(
   input  logic                                  ftap_tck,
   input  logic                                  tap_rtdr_prog_rst_b,
   input  logic                                  tap_rtdr_tdi,
   input  logic                                  tap_rtdr_capture,
   input  logic                                  tap_rtdr_shift,
   input  logic                                  tap_rtdr_update,
   input  logic                                  tap_rtdr_selectir,
   input  rtdr_pkg::rtdr_sel_t                   tap_rtdr_irdec,
   input  logic                                  stap_fbscan_shiftdr,
   input  logic                                  stap_fbscan_runbist_en,
   output logic                                  rtdr_tap_tdo,
   output rtdr_pkg::rtdr_word_t [`RTDR_NUM-1:0]  rtdr_tdr_out,
   output logic                                  stap_abscan_tdo
);

   import rtdr_pkg::*;

   // Per-cell strobes from control
   rtdr_ctrl_t [`RTDR_NUM-1:0] cell_ctrl;
   // Per-cell serial outputs back to control
   logic [`RTDR_NUM-1:0]       cell_tdo;

   // ------------------------------------------------------------------------
   // Strobe control and TDO select
   // ------------------------------------------------------------------------
   rtdr_ctrl i_rtdr_ctrl
   (
      .ftap_tck            (ftap_tck),
      .tap_rtdr_prog_rst_b (tap_rtdr_prog_rst_b),
      .tap_rtdr_capture    (tap_rtdr_capture),
      .tap_rtdr_shift      (tap_rtdr_shift),
      .tap_rtdr_update     (tap_rtdr_update),
      .tap_rtdr_selectir   (tap_rtdr_selectir),
      .tap_rtdr_irdec      (tap_rtdr_irdec),
      .cell_tdo            (cell_tdo),
      .cell_ctrl           (cell_ctrl),
      .rtdr_tap_tdo        (rtdr_tap_tdo)
   );

   // ------------------------------------------------------------------------
   // Remote register bank
   // ------------------------------------------------------------------------
   // All cells share the bussed TDI
   for (genvar i = 0; i < `RTDR_NUM; i++)
   begin : g_cell
      rtdr_cell i_rtdr_cell
      (
         .ftap_tck            (ftap_tck),
         .tap_rtdr_prog_rst_b (tap_rtdr_prog_rst_b),
         .tap_rtdr_tdi        (tap_rtdr_tdi),
         .cell_ctrl           (cell_ctrl[i]),
         .cell_tdo            (cell_tdo[i]),
         .tdr_out             (rtdr_tdr_out[i])
      );
   end

   // ------------------------------------------------------------------------
   // Boundary-scan chain model
   // ------------------------------------------------------------------------
   // Independent of the decode, same TDI
   bscan_emul i_bscan_emul
   (
      .ftap_tck               (ftap_tck),
      .tap_rtdr_prog_rst_b    (tap_rtdr_prog_rst_b),
      .ftap_tdi               (tap_rtdr_tdi),
      .stap_fbscan_shiftdr    (stap_fbscan_shiftdr),
      .stap_fbscan_runbist_en (stap_fbscan_runbist_en),
      .stap_abscan_tdo        (stap_abscan_tdo)
   );

endmodule

/* list.f */
+incdir+common
common/rtdr_pkg.sv
rtdr/rtdr_ctrl.sv
rtdr/rtdr_cell.sv
hw/bscan_emul.sv
hw/rtdr_top.sv
tb/tb_rtdr_top.sv

/* rtdr/rtdr_cell.sv */
// One remote data register with shift stage, shadow stage and serial output
`timescale 1ns/10ps
`include "rtdr_cfg.svh"

module rtdr_cell
(
   input  logic                 ftap_tck,
   input  logic                 tap_rtdr_prog_rst_b,
   input  logic                 tap_rtdr_tdi,
   input  rtdr_pkg::rtdr_ctrl_t cell_ctrl,
   output logic                 cell_tdo,
   output rtdr_pkg::rtdr_word_t tdr_out
);

   import rtdr_pkg::*;

   // Serial shift stage
   rtdr_word_t shift_q;
   // Parallel shadow stage, seen outside the block
   rtdr_word_t shadow_q;

   // ------------------------------------------------------------------------
   // Shift and shadow stages
   // ------------------------------------------------------------------------
   always_ff @(posedge ftap_tck or negedge tap_rtdr_prog_rst_b)
   begin
      if (!tap_rtdr_prog_rst_b)
      begin
         shift_q  <= `RTDR_RST_VAL;
         shadow_q <= `RTDR_RST_VAL;
      end
      else if (cell_ctrl.capture)
      begin
         // Shadow contents go out on the next scan
         shift_q <= shadow_q;
      end
      else if (cell_ctrl.shift)
      begin
         // Move right, new bit at the MSB
         shift_q <= {tap_rtdr_tdi, shift_q[`RTDR_WIDTH-1:1]};
      end
      else if (cell_ctrl.update)
      begin
         shadow_q <= shift_q;
      end
   end

   // ------------------------------------------------------------------------
   // Outputs
   // ------------------------------------------------------------------------
   // LSB leaves first
   assign cell_tdo = shift_q[0];
   assign tdr_out  = shadow_q;

endmodule

/* rtdr/rtdr_ctrl.sv */
// Strobe gating, strobe priority and TDO select for the remote TDR bank
`timescale 1ns/10ps
`include "rtdr_cfg.svh"

module rtdr_ctrl
(
   input  logic                                  ftap_tck,
   input  logic                                  tap_rtdr_prog_rst_b,
   input  logic                                  tap_rtdr_capture,
   input  logic                                  tap_rtdr_shift,
   input  logic                                  tap_rtdr_update,
   input  logic                                  tap_rtdr_selectir,
   input  rtdr_pkg::rtdr_sel_t                   tap_rtdr_irdec,
   input  logic [`RTDR_NUM-1:0]                  cell_tdo,
   output rtdr_pkg::rtdr_ctrl_t [`RTDR_NUM-1:0]  cell_ctrl,
   output logic                                  rtdr_tap_tdo
);

   import rtdr_pkg::*;

   // DR strobes allowed only outside an IR scan
   logic       dr_en;
   // Strobes after blocking and priority
   logic       cap_g;
   logic       shf_g;
   logic       upd_g;
   // Decode latched at capture
   rtdr_sel_t  irdec_q;
   // Decode that steers TDO this cycle
   rtdr_sel_t  tdo_sel;

   // ------------------------------------------------------------------------
   // Strobe blocking and priority
   // ------------------------------------------------------------------------
   assign dr_en = ~tap_rtdr_selectir;

   // Capture wins over shift, shift wins over update
   assign cap_g = tap_rtdr_capture & dr_en;
   assign shf_g = tap_rtdr_shift & dr_en & ~tap_rtdr_capture;
   assign upd_g = tap_rtdr_update & dr_en & ~tap_rtdr_capture & ~tap_rtdr_shift;

   // Fan out to each cell, qualified by its decode bit
   always_comb
   begin
      for (int i = 0; i < `RTDR_NUM; i++)
      begin
         cell_ctrl[i].capture = cap_g & tap_rtdr_irdec[i];
         cell_ctrl[i].shift   = shf_g & tap_rtdr_irdec[i];
         cell_ctrl[i].update  = upd_g & tap_rtdr_irdec[i];
      end
   end

   // ------------------------------------------------------------------------
   // Decode register
   // ------------------------------------------------------------------------
   // Holds the selection of the scan in progress
   always_ff @(posedge ftap_tck or negedge tap_rtdr_prog_rst_b)
   begin
      if (!tap_rtdr_prog_rst_b)
      begin
         irdec_q <= '0;
      end
      else if (cap_g)
      begin
         irdec_q <= tap_rtdr_irdec;
      end
   end

   // ------------------------------------------------------------------------
   // TDO select
   // ------------------------------------------------------------------------
   // Registered decode during shift keeps TDO steady through the scan
   assign tdo_sel = shf_g ? irdec_q : tap_rtdr_irdec;

   // Zero during IR scan or with nothing decoded
   assign rtdr_tap_tdo = dr_en & (|tap_rtdr_irdec) & (|(tdo_sel & cell_tdo));

endmodule

/* tb/rtdr_cases.txt */
# Columns: operation, register index, TDI data word in hex (rnd marks a don't-care stream),
# expected word in hex (shifted-out word, serial output word, or bit 0 for single bits)
reset         0    00    00
# First scans find the registers at zero
scan          0    a5    00
scan          1    3c    00
scan          2    81    00
# Second scan shifts the previous word out LSB first
scan          0    5a    a5
# Blocked strobes change nothing and TDO stays low
scan_ir       1    rnd   00
scan_nodec    0    rnd   00
scan          1    c3    3c
scan_ir       2    rnd   00
scan          2    ff    81
scan_nodec    2    rnd   00
scan          2    00    ff
scan          0    e7    5a
# Boundary chain, each bit shows up BSCAN_LEN edges after it entered
chain         0    b5    d4
chain         0    3c    f2
# Run-BIST output follows the TDI bit of the previous edge
bist          0    96    96
bist          0    3c    3c
# Back on the chain, which held its value through run-BIST
chain_out     0    00    01
chain         0    ff    fc

/* tb/tb_rtdr_top.sv */
// Testbench for the remote TDR block, played from the case file
`timescale 1ns/10ps
`include "rtdr_cfg.svh"

module tb_rtdr_top;

   import rtdr_pkg::*;

   // Cycles allowed for a shadow word to take an update
   localparam int UPD_TIMEOUT = 4;
   // Upper bound on case file lines
   localparam int MAX_LINES   = 200;

   logic                        ftap_tck;
   logic                        tap_rtdr_prog_rst_b;
   logic                        tap_rtdr_tdi;
   logic                        tap_rtdr_capture;
   logic                        tap_rtdr_shift;
   logic                        tap_rtdr_update;
   logic                        tap_rtdr_selectir;
   rtdr_sel_t                   tap_rtdr_irdec;
   logic                        stap_fbscan_shiftdr;
   logic                        stap_fbscan_runbist_en;
   logic                        rtdr_tap_tdo;
   rtdr_word_t [`RTDR_NUM-1:0]  rtdr_tdr_out;
   logic                        stap_abscan_tdo;

   // Shadow words expected from the accepted scans so far
   rtdr_word_t                  shadow_exp [`RTDR_NUM];

   rtdr_top i_rtdr_top
   (
      .ftap_tck               (ftap_tck),
      .tap_rtdr_prog_rst_b    (tap_rtdr_prog_rst_b),
      .tap_rtdr_tdi           (tap_rtdr_tdi),
      .tap_rtdr_capture       (tap_rtdr_capture),
      .tap_rtdr_shift         (tap_rtdr_shift),
      .tap_rtdr_update        (tap_rtdr_update),
      .tap_rtdr_selectir      (tap_rtdr_selectir),
      .tap_rtdr_irdec         (tap_rtdr_irdec),
      .stap_fbscan_shiftdr    (stap_fbscan_shiftdr),
      .stap_fbscan_runbist_en (stap_fbscan_runbist_en),
      .rtdr_tap_tdo           (rtdr_tap_tdo),
      .rtdr_tdr_out           (rtdr_tdr_out),
      .stap_abscan_tdo        (stap_abscan_tdo)
   );

   // 100 ns TCK
   initial
   begin
      ftap_tck = 1'b0;
      forever
      begin
         #50 ftap_tck = ~ftap_tck;
      end
   end

   // ------------------------------------------------------------------------
   // Failure and compare tasks
   // ------------------------------------------------------------------------
   task automatic stop_run();
      $display("TEST FAIL");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_word(input rtdr_word_t got, input rtdr_word_t exp, input string what);
      if (got !== exp)
      begin
         $display("ERROR %0t: %s is %02h, expected %02h", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_shadows();
      for (int k = 0; k < `RTDR_NUM; k++)
      begin
         check_word(rtdr_tdr_out[k], shadow_exp[k], $sformatf("shadow word %0d", k));
      end
   endtask

   // ------------------------------------------------------------------------
   // Stimulus tasks
   // ------------------------------------------------------------------------
   // Inputs change 5 ns after the rising edge
   task automatic next_drive_slot();
      @(posedge ftap_tck);
      #5;
   endtask

   // Capture, RTDR_WIDTH shifts, update; TDO bits collected LSB first
   task automatic scan_dr(input rtdr_sel_t dec, input logic in_ir, input rtdr_word_t data,
                          output rtdr_word_t tdo_word);
      next_drive_slot();
      tap_rtdr_irdec    = dec;
      tap_rtdr_selectir = in_ir;
      tap_rtdr_capture  = 1'b1;
      for (int i = 0; i < `RTDR_WIDTH; i++)
      begin
         next_drive_slot();
         tap_rtdr_capture = 1'b0;
         tap_rtdr_shift   = 1'b1;
         tap_rtdr_tdi     = data[i];
         // Mid-cycle, ahead of the shifting edge
         @(negedge ftap_tck);
         tdo_word[i] = rtdr_tap_tdo;
      end
      next_drive_slot();
      tap_rtdr_shift  = 1'b0;
      tap_rtdr_update = 1'b1;
      tap_rtdr_tdi    = 1'b0;
      next_drive_slot();
      tap_rtdr_update   = 1'b0;
      tap_rtdr_irdec    = '0;
      tap_rtdr_selectir = 1'b0;
   endtask

   // Chain shift or run-BIST, one TDI bit per edge, output sampled after each edge
   task automatic run_abscan(input logic bist, input rtdr_word_t data,
                             output rtdr_word_t out_word);
      for (int i = 0; i <= `RTDR_WIDTH; i++)
      begin
         next_drive_slot();
         if (i > 0)
         begin
            out_word[i-1] = stap_abscan_tdo;
         end
         if (i < `RTDR_WIDTH)
         begin
            stap_fbscan_shiftdr    = ~bist;
            stap_fbscan_runbist_en = bist;
            tap_rtdr_tdi           = data[i];
         end
         else
         begin
            stap_fbscan_shiftdr    = 1'b0;
            stap_fbscan_runbist_en = 1'b0;
            tap_rtdr_tdi           = 1'b0;
         end
      end
   endtask

   // Waits for the shadow word of one register to take the scanned value
   task automatic wait_shadow(input int idx, input rtdr_word_t data);
      int cyc;
      cyc = 0;
      while (rtdr_tdr_out[idx] !== data && cyc < UPD_TIMEOUT)
      begin
         @(negedge ftap_tck);
         cyc++;
      end
      if (rtdr_tdr_out[idx] !== data)
      begin
         $display("Shadow word %0d did not take the scanned value within %0d cycles",
                  idx, UPD_TIMEOUT);
         stop_run();
      end
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial
   begin
      int          fd;
      int          nfields;
      int          line_no;
      int          ncases;
      int          idx;
      string       line;
      string       op;
      string       dtok;
      rtdr_word_t  data;
      rtdr_word_t  exp;
      rtdr_word_t  got;
      rtdr_sel_t   dec;

      // Fixed seed for the don't-care TDI bits
      void'($urandom(32'h07ee09cf));
      tap_rtdr_prog_rst_b    = 1'b0;
      tap_rtdr_tdi           = 1'b0;
      tap_rtdr_capture       = 1'b0;
      tap_rtdr_shift         = 1'b0;
      tap_rtdr_update        = 1'b0;
      tap_rtdr_selectir      = 1'b0;
      tap_rtdr_irdec         = '0;
      stap_fbscan_shiftdr    = 1'b0;
      stap_fbscan_runbist_en = 1'b0;
      for (int k = 0; k < `RTDR_NUM; k++)
      begin
         shadow_exp[k] = `RTDR_RST_VAL;
      end

      // Reset low for 10 cycles
      for (int c = 0; c < 10; c++)
      begin
         @(posedge ftap_tck);
      end
      #5;
      tap_rtdr_prog_rst_b = 1'b1;

      fd = $fopen("tb/rtdr_cases.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the case file tb/rtdr_cases.txt");
         stop_run();
      end
      line_no = 0;
      ncases  = 0;
      while (!$feof(fd) && line_no < MAX_LINES)
      begin
         line_no++;
         line = "";
         void'($fgets(line, fd));
         // Comment and empty lines carry no case
         if (line.len() > 1 && line.getc(0) != "#")
         begin
            nfields = $sscanf(line, "%s %d %s %h", op, idx, dtok, exp);
            if (nfields != 4 || idx < 0 || idx >= `RTDR_NUM)
            begin
               $display("Case file line %0d is malformed", line_no);
               stop_run();
            end
            // Don't-care TDI stream
            if (dtok == "rnd")
            begin
               data = rtdr_word_t'($urandom);
            end
            else
            begin
               void'($sscanf(dtok, "%h", data));
            end
            dec      = '0;
            dec[idx] = 1'b1;
            ncases++;
            case (op)
               "reset":
               begin
                  next_drive_slot();
                  for (int k = 0; k < `RTDR_NUM; k++)
                  begin
                     check_word(rtdr_tdr_out[k], exp, $sformatf("reset word %0d", k));
                  end
                  check_bit(rtdr_tap_tdo, exp[0], "rtdr_tap_tdo after reset");
                  check_bit(stap_abscan_tdo, exp[0], "stap_abscan_tdo after reset");
               end
               "scan":
               begin
                  scan_dr(dec, 1'b0, data, got);
                  check_word(got, exp, "shifted-out word");
                  shadow_exp[idx] = data;
                  wait_shadow(idx, data);
                  check_shadows();
               end
               "scan_ir":
               begin
                  scan_dr(dec, 1'b1, data, got);
                  check_word(got, exp, "TDO during IR scan");
                  check_shadows();
               end
               "scan_nodec":
               begin
                  scan_dr('0, 1'b0, data, got);
                  check_word(got, exp, "TDO with no decode");
                  check_shadows();
               end
               "chain":
               begin
                  run_abscan(1'b0, data, got);
                  check_word(got, exp, "chain output");
               end
               "bist":
               begin
                  run_abscan(1'b1, data, got);
                  check_word(got, exp, "run-BIST output");
               end
               "chain_out":
               begin
                  next_drive_slot();
                  check_bit(stap_abscan_tdo, exp[0], "chain bit 0");
               end
               default:
               begin
                  $display("Unknown operation %s on case file line %0d", op, line_no);
                  stop_run();
               end
            endcase
         end
      end
      if (!$feof(fd))
      begin
         $display("Case file is longer than %0d lines", MAX_LINES);
         stop_run();
      end
      $fclose(fd);

      if (ncases == 0)
      begin
         $display("Case file holds no cases");
         stop_run();
      end
      else
      begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule
